//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
RTL_TOP   ?= coreTop
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop (
  input  logic             gclk,
  input  logic             grst,
  input  logic             instrValid,
  input  cpuPkg::instrWord instrData,
  output logic             instrCredit,
  input  logic             irq,
  input  logic             irqEnable,
  output logic             resValid,
  output logic             resIrq,
  output cpuPkg::regAddr   resReg,
  output cpuPkg::dataWord  resData,
  input  logic             resCredit
);

  // Global stall from the result credits
  logic advance;

  // Decode to execute
  logic            decValid;
  logic            decIrq;
  logic            decUseImm;
  cpuPkg::opcode   decOpc;
  cpuPkg::regAddr  decRd;
  cpuPkg::regAddr  decRa;
  cpuPkg::regAddr  decRb;
  cpuPkg::dataWord decImm;

  // Register file read side
  cpuPkg::regAddr  rdAddrA;
  cpuPkg::regAddr  rdAddrB;
  cpuPkg::dataWord rdDataA;
  cpuPkg::dataWord rdDataB;

  // Execute to result
  logic            exValid;
  logic            exIrq;
  cpuPkg::regAddr  exReg;
  cpuPkg::dataWord exData;

  // Write-back, also the second bypass source
  logic            wbValid;
  cpuPkg::regAddr  wbReg;
  cpuPkg::dataWord wbData;

  // Port names match the nets above
  instrBuffer uInstrBuffer (.*);

  execUnit uExecUnit (.*);

  regFile uRegFile (
    .gclk,
    .rdAddrA,
    .rdAddrB,
    .rdDataA,
    .rdDataB,
    .wrEn   (wbValid),
    .wrAddr (wbReg),
    .wrData (wbData)
  );

  resultStage uResultStage (.*);

endmodule

`default_nettype wire

//--- logic/cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Major opcodes, MicroBlaze numbering
`define OPC_ADD  6'h00
`define OPC_SUB  6'h01
`define OPC_ADDI 6'h08
`define OPC_OR   6'h20
`define OPC_AND  6'h21
`define OPC_XOR  6'h22
`define OPC_ORI  6'h28
// Prefix carrying the upper immediate half
`define OPC_IMM  6'h2C

// Instruction queue entries
// Also the sender's credit count after reset
`define IQ_DEPTH 2

// Result credits held by the core after reset
`define RES_CREDITS 4

// Value written by the interrupt record
`define INT_VECTOR 32'h0000_0010
// Link register for the interrupt record
`define INT_LINK_REG 5'd14

`endif

//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // Raw instruction word from the sender
  typedef logic [31:0] instrWord;

  // Operand, immediate or result value
  typedef logic [31:0] dataWord;

  // Register index, 32 registers
  typedef logic [4:0] regAddr;

  // Major opcode, top six bits of the word
  typedef logic [5:0] opcode;

  // Low immediate field, also the IMM prefix payload
  typedef logic [15:0] imm16;

  // Interrupt latch
  // Pending until injected, issued until irq drops
  typedef enum logic [1:0] {
    IRQ_IDLE,
    IRQ_PENDING,
    IRQ_ISSUED
  } irqState;

endpackage

`default_nettype wire

//--- logic/execUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuConsts.svh"

module execUnit (
  input  logic            gclk,
  input  logic            grst,
  input  logic            advance,
  input  logic            decValid,
  input  logic            decIrq,
  input  logic            decUseImm,
  input  cpuPkg::opcode   decOpc,
  input  cpuPkg::regAddr  decRd,
  input  cpuPkg::regAddr  decRa,
  input  cpuPkg::regAddr  decRb,
  input  cpuPkg::dataWord decImm,
  output cpuPkg::regAddr  rdAddrA,
  output cpuPkg::regAddr  rdAddrB,
  input  cpuPkg::dataWord rdDataA,
  input  cpuPkg::dataWord rdDataB,
  input  logic            wbValid,
  input  cpuPkg::regAddr  wbReg,
  input  cpuPkg::dataWord wbData,
  output logic            exValid,
  output logic            exIrq,
  output cpuPkg::regAddr  exReg,
  output cpuPkg::dataWord exData
);

  logic            hitExA;
  logic            hitWbA;
  logic            hitExB;
  logic            hitWbB;
  cpuPkg::dataWord regA;
  cpuPkg::dataWord regB;
  cpuPkg::dataWord opB;
  cpuPkg::dataWord aluOut;
  logic            aluKnown;

  // Register file read straight from the decode register
  assign rdAddrA = decRa;
  assign rdAddrB = decRb;

  // Newer result sits in our own output register
  assign hitExA = exValid && (exReg == decRa) && (decRa != '0);
  assign hitExB = exValid && (exReg == decRb) && (decRb != '0);
  // Older one is still waiting on the write port
  assign hitWbA = wbValid && (wbReg == decRa) && (decRa != '0);
  assign hitWbB = wbValid && (wbReg == decRb) && (decRb != '0);

  // Youngest producer wins
  assign regA = hitExA ? exData : (hitWbA ? wbData : rdDataA);
  assign regB = hitExB ? exData : (hitWbB ? wbData : rdDataB);

  assign opB = decUseImm ? decImm : regB;

  always_comb begin
    aluOut   = '0;
    aluKnown = 1'b1;
    case (decOpc)
      `OPC_ADD,
      `OPC_ADDI: aluOut = regA + opB;
      // rd = ra - rb
      `OPC_SUB:  aluOut = regA - opB;
      `OPC_AND:  aluOut = regA & opB;
      `OPC_OR,
      `OPC_ORI:  aluOut = regA | opB;
      `OPC_XOR:  aluOut = regA ^ opB;
      // Anything else retires without a record
      default:   aluKnown = 1'b0;
    endcase
  end

  // Execute register control
  always_ff @(posedge gclk) begin
    if (!grst) begin
      exValid <= 1'b0;
      exIrq   <= 1'b0;
    end else if (advance) begin
      exValid <= decValid && (decIrq || aluKnown);
      exIrq   <= decValid && decIrq;
    end
  end

  // Execute payload
  always_ff @(posedge gclk) begin
    if (advance) begin
      // Interrupt record loads the vector into the link register
      exReg  <= decIrq ? `INT_LINK_REG : decRd;
      exData <= decIrq ? `INT_VECTOR : aluOut;
    end
  end

endmodule

`default_nettype wire

//--- logic/instrBuffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuConsts.svh"

module instrBuffer (
  input  logic             gclk,
  input  logic             grst,
  input  logic             advance,
  input  logic             instrValid,
  input  cpuPkg::instrWord instrData,
  input  logic             irq,
  input  logic             irqEnable,
  output logic             instrCredit,
  output logic             decValid,
  output logic             decIrq,
  output logic             decUseImm,
  output cpuPkg::opcode    decOpc,
  output cpuPkg::regAddr   decRd,
  output cpuPkg::regAddr   decRa,
  output cpuPkg::regAddr   decRb,
  output cpuPkg::dataWord  decImm
);

  localparam int ptrWidth = $clog2(`IQ_DEPTH);

  cpuPkg::instrWord    queueMem [`IQ_DEPTH];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   count;

  cpuPkg::instrWord headWord;
  cpuPkg::opcode    headOpc;
  cpuPkg::imm16     headImm;
  logic             headIsImm;
  logic             headUsesImm;

  logic [1:0]      irqSync;
  cpuPkg::irqState irqSt;
  logic            immHeld;
  cpuPkg::imm16    immHi;
  logic            inject;
  logic            pop;

  // Wrap for any queue depth
  function automatic logic [ptrWidth-1:0] bumpPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(`IQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign headWord    = queueMem[rdPtr];
  assign headOpc     = headWord[31:26];
  assign headImm     = headWord[15:0];
  assign headIsImm   = (headOpc == `OPC_IMM);
  assign headUsesImm = (headOpc == `OPC_ADDI) || (headOpc == `OPC_ORI);

  // Never split a prefix from its instruction
  assign inject = (irqSt == cpuPkg::IRQ_PENDING) && !immHeld;
  // Injection takes the decode slot instead of a pop
  assign pop    = advance && !inject && (count != '0);

  // Queue storage, sender credits guarantee space
  always_ff @(posedge gclk) begin
    if (instrValid) begin
      queueMem[wrPtr] <= instrData;
    end
  end

  always_ff @(posedge gclk) begin
    if (!grst) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      instrCredit <= 1'b0;
    end else begin
      if (instrValid) begin
        wrPtr <= bumpPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= bumpPtr(rdPtr);
      end
      case ({instrValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per freed entry
      instrCredit <= pop;
    end
  end

  // Two-flop sync, then latch the level
  always_ff @(posedge gclk) begin
    if (!grst) begin
      irqSync <= 2'b00;
      irqSt   <= cpuPkg::IRQ_IDLE;
    end else begin
      irqSync <= {irqSync[0], irq};
      case (irqSt)
        cpuPkg::IRQ_IDLE: begin
          if (irqSync[1] && irqEnable) begin
            irqSt <= cpuPkg::IRQ_PENDING;
          end
        end
        cpuPkg::IRQ_PENDING: begin
          // Disable drops a request not yet taken
          if (!irqEnable) begin
            irqSt <= cpuPkg::IRQ_IDLE;
          end else if (advance && inject) begin
            irqSt <= cpuPkg::IRQ_ISSUED;
          end
        end
        cpuPkg::IRQ_ISSUED: begin
          // One record per assertion of the level
          if (!irqSync[1]) begin
            irqSt <= cpuPkg::IRQ_IDLE;
          end
        end
        default: irqSt <= cpuPkg::IRQ_IDLE;
      endcase
    end
  end

  // Decode register control
  always_ff @(posedge gclk) begin
    if (!grst) begin
      decValid  <= 1'b0;
      decIrq    <= 1'b0;
      decUseImm <= 1'b0;
      immHeld   <= 1'b0;
    end else if (advance) begin
      if (inject) begin
        decValid  <= 1'b1;
        decIrq    <= 1'b1;
        decUseImm <= 1'b0;
      end else if (pop && headIsImm) begin
        // Prefix produces no operation
        decValid <= 1'b0;
        decIrq   <= 1'b0;
        immHeld  <= 1'b1;
      end else if (pop) begin
        decValid  <= 1'b1;
        decIrq    <= 1'b0;
        decUseImm <= headUsesImm;
        immHeld   <= 1'b0;
      end else begin
        decValid <= 1'b0;
        decIrq   <= 1'b0;
      end
    end
  end

  // Decoded fields and the held upper half
  always_ff @(posedge gclk) begin
    if (pop) begin
      if (headIsImm) begin
        immHi <= headImm;
      end
      decOpc <= headOpc;
      decRd  <= headWord[25:21];
      decRa  <= headWord[20:16];
      decRb  <= headWord[15:11];
      // Joined with a prefix, else sign extended
      decImm <= immHeld ? {immHi, headImm} : {{16{headImm[15]}}, headImm};
    end
  end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic            gclk,
  input  cpuPkg::regAddr  rdAddrA,
  input  cpuPkg::regAddr  rdAddrB,
  output cpuPkg::dataWord rdDataA,
  output cpuPkg::dataWord rdDataB,
  input  logic            wrEn,
  input  cpuPkg::regAddr  wrAddr,
  input  cpuPkg::dataWord wrData
);

  // 32 general registers
  cpuPkg::dataWord regs [32];

  // Single write port, r0 never stored
  always_ff @(posedge gclk) begin
    if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Asynchronous reads
  // r0 forced to zero on both ports
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- logic/resultStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuConsts.svh"

module resultStage (
  input  logic            gclk,
  input  logic            grst,
  input  logic            exValid,
  input  logic            exIrq,
  input  cpuPkg::regAddr  exReg,
  input  cpuPkg::dataWord exData,
  input  logic            resCredit,
  output logic            advance,
  output logic            resValid,
  output logic            resIrq,
  output cpuPkg::regAddr  resReg,
  output cpuPkg::dataWord resData,
  output logic            wbValid,
  output cpuPkg::regAddr  wbReg,
  output cpuPkg::dataWord wbData
);

  localparam int creditWidth = $clog2(`RES_CREDITS + 1);

  logic [creditWidth-1:0] creditCnt;
  logic                   load;

  // Whole pipeline moves only with a credit in hand
  assign advance = (creditCnt != '0);
  assign load    = advance && exValid;

  // Credit is taken when a record is loaded
  // so resValid can never outrun the grant
  always_ff @(posedge gclk) begin
    if (!grst) begin
      creditCnt <= creditWidth'(`RES_CREDITS);
      resValid  <= 1'b0;
      resIrq    <= 1'b0;
    end else begin
      case ({resCredit, load})
        2'b10:   creditCnt <= creditCnt + 1'b1;
        2'b01:   creditCnt <= creditCnt - 1'b1;
        default: creditCnt <= creditCnt;
      endcase
      // Single-cycle strobe per record
      resValid <= load;
      resIrq   <= load && exIrq;
    end
  end

  always_ff @(posedge gclk) begin
    if (load) begin
      resReg  <= exReg;
      resData <= exData;
    end
  end

  // Record commits to the register file on the same strobe
  assign wbValid = resValid;
  assign wbReg   = resReg;
  assign wbData  = resData;

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/cpuPkg.sv
logic/instrBuffer.sv
logic/execUnit.sv
logic/regFile.sv
logic/resultStage.sv
logic/coreTop.sv
tb/coreTb.sv

//--- tb/coreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpuConsts.svh"

module coreTb;

  logic             gclk = 1'b0;
  logic             grst = 1'b0;
  logic             instrValid = 1'b0;
  cpuPkg::instrWord instrData = '0;
  logic             instrCredit;
  logic             irq = 1'b0;
  logic             irqEnable = 1'b0;
  logic             resValid;
  logic             resIrq;
  cpuPkg::regAddr   resReg;
  cpuPkg::dataWord  resData;
  logic             resCredit = 1'b0;

  // Parsed contents of the data file
  string       testNames[$];
  int          irqPerTest[$];
  int          itemTest[$];
  bit          itemIsIrq[$];
  logic [31:0] itemVal[$];
  int          expTest[$];
  logic [4:0]  expRegAll[$];
  logic [31:0] expValAll[$];
  int          instrTotal = 0;
  bit          fileOk = 1'b0;
  bit          parsed = 1'b0;

  // Scoreboard state
  string       curName = "reset";
  int          expLimit = 0;
  int          expIdx = 0;
  int          irqWant = 0;
  int          irqGot = 0;
  int          valueErrors = 0;
  int          protoErrors = 0;
  int          cycleNo = 0;

  // Credit bookkeeping on both sides
  int          wordsSent = 0;
  int          creditPulses = 0;
  int          resCount = 0;
  int          returned = 0;
  int          grantedPrior = 0;
  int          prevPulse = 0;
  logic [31:0] rngState = 32'h8372_bd0e;

  coreTop u_dut (.*);

  always #5 gclk = ~gclk;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("FAILED test %s, %s: expected %h, actual %h", curName, what, expected, actual);
    end
  endtask

  task automatic reportProblem(input string what);
    protoErrors++;
    $display("Error in test %s: %s", curName, what);
  endtask

  task automatic readTests(output bit ok);
    int          fd;
    int          n;
    int          num;
    string       line;
    string       tag;
    string       nm;
    logic [31:0] v;
    fd = $fopen("tb/coreTests.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      ok = 1'b1;
      while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s", tag);
        if (n == 1 && tag == "T") begin
          n = $sscanf(line, "%s %s", tag, nm);
          testNames.push_back(nm);
          irqPerTest.push_back(0);
        end else if (n == 1 && tag == "I") begin
          n = $sscanf(line, "%s %h", tag, v);
          itemTest.push_back(testNames.size() - 1);
          itemIsIrq.push_back(1'b0);
          itemVal.push_back(v);
          instrTotal++;
        end else if (n == 1 && tag == "Q") begin
          n = $sscanf(line, "%s %d", tag, num);
          itemTest.push_back(testNames.size() - 1);
          itemIsIrq.push_back(1'b1);
          itemVal.push_back(32'(num));
          // Only enabled events owe a record
          if (num != 0) begin
            irqPerTest[testNames.size() - 1]++;
          end
        end else if (n == 1 && tag == "E") begin
          n = $sscanf(line, "%s %d %h", tag, num, v);
          expTest.push_back(testNames.size() - 1);
          expRegAll.push_back(5'(num));
          expValAll.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic sendWord(input logic [31:0] w);
    while ((`IQ_DEPTH + creditPulses - wordsSent) <= 0) begin
      instrValid = 1'b0;
      @(negedge gclk);
    end
    instrValid = 1'b1;
    instrData  = w;
    wordsSent++;
    @(negedge gclk);
    instrValid = 1'b0;
  endtask

  // Level held long enough to cross the synchronizer
  task automatic irqEvent(input bit en);
    irqEnable = en;
    irq       = 1'b1;
    repeat (8) @(negedge gclk);
    irq = 1'b0;
    repeat (4) @(negedge gclk);
  endtask

  task automatic runTest(input int t);
    curName = testNames[t];
    irqWant += irqPerTest[t];
    foreach (expTest[i]) begin
      if (expTest[i] == t) begin
        expLimit++;
      end
    end
    foreach (itemTest[i]) begin
      if (itemTest[i] == t) begin
        if (itemIsIrq[i]) begin
          irqEvent(itemVal[i][0]);
        end else begin
          sendWord(itemVal[i]);
        end
      end
    end
    // Drain, then idle to catch stray records
    while (expIdx < expLimit || irqGot < irqWant) begin
      @(negedge gclk);
    end
    repeat (20) @(negedge gclk);
  endtask

  // Consumer returns owed credits on about one cycle in four
  always @(negedge gclk) begin
    if (!grst) begin
      resCredit = 1'b0;
    end else begin
      rngState = lcgNext(rngState);
      if ((resCount - returned) > 0 && rngState[17:16] == 2'b00) begin
        resCredit = 1'b1;
        returned++;
      end else begin
        resCredit = 1'b0;
      end
    end
  end

  // Result and credit monitor
  always @(posedge gclk) begin
    cycleNo++;
    // Outputs idle through reset and the first cycle after it
    if (cycleNo >= 2 && cycleNo <= 12) begin
      checkValue("resValid idle", 32'd0, {31'd0, resValid});
      checkValue("instrCredit idle", 32'd0, {31'd0, instrCredit});
    end
    if (grst) begin
      if (resValid) begin
        if ((`RES_CREDITS + grantedPrior - resCount) <= 0) begin
          reportProblem("resValid seen with no result credit left");
        end
        resCount++;
        if (resIrq) begin
          irqGot++;
          if (irqGot > irqWant) begin
            reportProblem("interrupt record that no enabled irq asked for");
          end
          checkValue("irq reg", {27'd0, `INT_LINK_REG}, {27'd0, resReg});
          checkValue("irq data", `INT_VECTOR, resData);
        end else if (expIdx >= expLimit) begin
          reportProblem("result record that was not expected");
        end else begin
          checkValue("reg", {27'd0, expRegAll[expIdx]}, {27'd0, resReg});
          checkValue("data", expValAll[expIdx], resData);
          expIdx++;
        end
      end
      // Credit pulse counts from the edge after it was sampled
      grantedPrior += prevPulse;
      prevPulse = int'(resCredit);
      if (instrCredit) begin
        creditPulses++;
        if (creditPulses > wordsSent) begin
          reportProblem("more instruction credits returned than words sent");
        end
      end
    end
  end

  // Watchdog sized at 200 cycles per instruction
  initial begin
    wait (parsed);
    repeat (200 * instrTotal + 20) @(posedge gclk);
    $display("Timeout: run exceeded the cycle budget for %0d instructions", instrTotal);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    readTests(fileOk);
    if (!fileOk) begin
      $display("Could not open the test data file tb/coreTests.txt");
      $display("TESTS FAILED");
      $finish;
    end else begin
      parsed = 1'b1;
      repeat (10) @(negedge gclk);
      grst = 1'b1;
      @(negedge gclk);
      for (int t = 0; t < testNames.size(); t++) begin
        runTest(t);
      end
      $display("Run complete: %0d value errors, %0d protocol errors", valueErrors, protoErrors);
      if (valueErrors + protoErrors == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb/coreTests.txt
# T name | I instruction word hex | Q irq event, 1 enabled 0 disabled
# E expected record, register decimal then value hex
T alu
I 20200005
I 20400003
I 00611000
I 04811000
I 84A11000
I 80C11000
I 88611000
I 20010007
I 00801000
I FC000000
I 00A42000
E 1 00000005
E 2 00000003
E 3 00000008
E 4 00000002
E 5 00000001
E 6 00000007
E 3 00000006
E 0 0000000C
E 4 00000003
E 5 00000006
T imm
I 2020FFFE
I A0408001
I B0001234
I 20605678
I B000ABCD
I A0810001
I 20A38000
E 1 FFFFFFFE
E 2 FFFF8001
E 3 12345678
E 4 FFFFFFFF
E 5 1233D678
T chain
I 20200010
I 20210001
I 20210001
I 20210001
I 20210001
I 20210001
I 88410800
E 1 00000010
E 1 00000011
E 1 00000012
E 1 00000013
E 1 00000014
E 1 00000015
E 2 00000000
T irq
I 20200001
Q 1
I 20410002
I B0000001
Q 1
I 20600002
I 00831000
E 1 00000001
E 2 00000003
E 3 00010002
E 4 00010005
T irqoff
Q 0
I 20200009
Q 0
I 20410001
E 1 00000009
E 2 0000000A
